/* control_encoder.sv */
`timescale 1ns/10ps
`include "cpu_ctl_cfg.svh"

module control_encoder import cpu_ctl_pkg::*; (
    input  logic                                           clk,
    input  logic                                           reset,
    input  uop_t                                           uop,
    input  logic                                           uop_valid,
    output logic                                           uop_ready,
    output logic                                           ctl_valid,
    input  logic                                           ctl_ready,
    output logic [`CPU_CTL_NUM_REGS-1:0]                   write_en,
    output logic [`CPU_CTL_NUM_REGS*`CPU_CTL_NUM_BUSES-1:0] output_en,
    output alu_op_t                                        alu_op,
    output logic [3:0]                                     alu_logic_func,
    output logic                                           alu_cin,
    output logic [`CPU_CTL_ROUTE_W-1:0]                    ctl_route,
    output logic [`CPU_CTL_WORD_W-1:0]                     immediate,
    input  logic                                           alu_cout
);

    logic                                           carry;
    logic                                           carry_now;
    logic                                           sets_carry_q;
    logic                                           uop_fire;
    logic                                           ctl_fire;
    logic [`CPU_CTL_NUM_REGS-1:0]                   write_en_d;
    logic [`CPU_CTL_NUM_REGS*`CPU_CTL_NUM_BUSES-1:0] output_en_d;
    logic                                           cin_d;
    logic [`CPU_CTL_ROUTE_W-1:0]                    route_d;

    assign uop_ready = !ctl_valid || ctl_ready;
    assign uop_fire  = uop_valid && uop_ready;
    assign ctl_fire  = ctl_valid && ctl_ready;

    // The carry out of a word leaving now feeds the word taken on the same edge
    assign carry_now = (ctl_fire && sets_carry_q) ? alu_cout : carry;

    ////////////////////////////////////////
    // Next control word
    ////////////////////////////////////////

    always_comb begin
        write_en_d  = '0;
        output_en_d = '0;
        write_en_d[uop.dest] = 1'b1;
        // Three enable bits per register, bus A in the lowest
        for (int b = 0; b < `CPU_CTL_NUM_BUSES; b++) begin
            if (uop.bus_en[b]) begin
                output_en_d[uop.bus_reg[b] * `CPU_CTL_NUM_BUSES + b] = 1'b1;
            end
        end
    end

    always_comb begin
        case (uop.alu_op)
            ALU_ADD:           cin_d = uop.use_carry ? carry_now : 1'b0;
            ALU_SUB:           cin_d = uop.use_carry ? carry_now : 1'b1;
            ALU_ROT, ALU_ROTC: cin_d = carry_now;
            default:           cin_d = 1'b0;
        endcase
    end

    always_comb begin
        case (uop.kind)
            UOP_ALU_RR: route_d = `CPU_CTL_ROUTE_ALU_RR;
            UOP_ALU_RI: route_d = `CPU_CTL_ROUTE_ALU_RI;
            UOP_IMM:    route_d = `CPU_CTL_ROUTE_IMM;
            default:    route_d = `CPU_CTL_ROUTE_PC;
        endcase
    end

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctl_valid    <= 1'b0;
            write_en     <= '0;
            output_en    <= '0;
            carry        <= 1'b0;
            sets_carry_q <= 1'b0;
        end else begin
            carry <= carry_now;
            if (uop_fire) begin
                ctl_valid    <= 1'b1;
                write_en     <= write_en_d;
                output_en    <= output_en_d;
                sets_carry_q <= uop.sets_carry;
            end else if (ctl_fire) begin
                ctl_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (uop_fire) begin
            alu_op         <= uop.alu_op;
            alu_logic_func <= uop.logic_func;
            alu_cin        <= cin_d;
            ctl_route      <= route_d;
            immediate      <= uop.imm;
        end
    end

    write_en_onehot: assert property (
        @(posedge clk) disable iff (reset)
        ctl_valid |-> $onehot0(write_en)
    ) else $error("control word writes more than one register");

endmodule

/* cpu_ctl_cfg.svh */
`ifndef CPU_CTL_CFG_SVH
`define CPU_CTL_CFG_SVH

// Datapath geometry
`define CPU_CTL_NUM_REGS     16
`define CPU_CTL_NUM_BUSES    3
`define CPU_CTL_WORD_W       16
`define CPU_CTL_BYTE_W       8
`define CPU_CTL_INSN_W       32
`define CPU_CTL_ROUTE_W      11

// Register 0 is the PC and register 15 takes the return address of CALL
`define CPU_CTL_PC_REG       4'd0
`define CPU_CTL_LINK_REG     4'd15

// Opcodes, found in bits 7:4 of the first instruction byte
`define CPU_CTL_OP_PUSH      4'h0
`define CPU_CTL_OP_POP       4'h1
`define CPU_CTL_OP_LFUN_RR   4'h2
`define CPU_CTL_OP_ADD_RR    4'h3
`define CPU_CTL_OP_SUB_RR    4'h4
`define CPU_CTL_OP_ROT_RR    4'h5
`define CPU_CTL_OP_ROT_RC    4'h6
`define CPU_CTL_OP_ADD_RC    4'h7
`define CPU_CTL_OP_MOV_RC    4'h8
`define CPU_CTL_OP_CALL      4'h9
`define CPU_CTL_OP_LFUN_RC   4'hA
`define CPU_CTL_OP_BEZ       4'hB
`define CPU_CTL_OP_BNEZ      4'hC
`define CPU_CTL_OP_BGEZ      4'hD
`define CPU_CTL_OP_LOAD      4'hE
`define CPU_CTL_OP_STORE     4'hF

// ALU operation codes
`define CPU_CTL_ALU_ADD      4'd0
`define CPU_CTL_ALU_ROTC     4'd1
`define CPU_CTL_ALU_SUB      4'd2
`define CPU_CTL_ALU_ROT      4'd3
`define CPU_CTL_ALU_LOGIC    4'd4
`define CPU_CTL_ALU_BEZ      4'd5
`define CPU_CTL_ALU_BNEZ     4'd6
`define CPU_CTL_ALU_BGEZ     4'd7

// Route codes steering the register input mux
`define CPU_CTL_ROUTE_ALU_RR 11'b00010000011
`define CPU_CTL_ROUTE_ALU_RI 11'b00010000101
`define CPU_CTL_ROUTE_IMM    11'b00101000000
`define CPU_CTL_ROUTE_PC     11'b00001000000

`endif

/* cpu_ctl_pkg.sv */
`include "cpu_ctl_cfg.svh"

package cpu_ctl_pkg;

    typedef logic [$clog2(`CPU_CTL_NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD   = `CPU_CTL_ALU_ADD,
        ALU_ROTC  = `CPU_CTL_ALU_ROTC,
        ALU_SUB   = `CPU_CTL_ALU_SUB,
        ALU_ROT   = `CPU_CTL_ALU_ROT,
        ALU_LOGIC = `CPU_CTL_ALU_LOGIC,
        ALU_BEZ   = `CPU_CTL_ALU_BEZ,
        ALU_BNEZ  = `CPU_CTL_ALU_BNEZ,
        ALU_BGEZ  = `CPU_CTL_ALU_BGEZ
    } alu_op_t;

    // Assembled instruction with byte 0 in the low bits
    // The short immediate spans bits 23:8 and so overlaps b, c and imm_hi
    typedef struct packed {
        logic [`CPU_CTL_WORD_W-1:0] imm_hi;
        reg_idx_t                   b;
        reg_idx_t                   c;
        logic [3:0]                 opcode;
        reg_idx_t                   a;
    } insn_t;

    // What a micro-step writes into its destination register
    typedef enum logic [1:0] {
        UOP_ALU_RR,
        UOP_ALU_RI,
        UOP_IMM,
        UOP_PC
    } uop_kind_t;

    // One micro-step, bus index 0 is bus A, 1 is bus B, 2 is bus C
    typedef struct packed {
        uop_kind_t                                kind;
        reg_idx_t                                 dest;
        logic [`CPU_CTL_NUM_BUSES-1:0]            bus_en;
        reg_idx_t [`CPU_CTL_NUM_BUSES-1:0]        bus_reg;
        logic                                     use_carry;
        alu_op_t                                  alu_op;
        logic [3:0]                               logic_func;
        logic [`CPU_CTL_WORD_W-1:0]               imm;
        logic                                     sets_carry;
    } uop_t;

    function automatic logic [`CPU_CTL_WORD_W-1:0] short_imm(input insn_t i);
        return {i.imm_hi[7:0], i.b, i.c};
    endfunction

    function automatic logic [`CPU_CTL_WORD_W-1:0] long_imm(input insn_t i);
        return i.imm_hi;
    endfunction

endpackage

/* cpu_ctl_top.sv */
`timescale 1ns/10ps
`include "cpu_ctl_cfg.svh"

module cpu_ctl_top import cpu_ctl_pkg::*; (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic [`CPU_CTL_BYTE_W-1:0]                     byte_data,
    input  logic                                           byte_valid,
    output logic                                           byte_ready,
    output logic                                           ctl_valid,
    input  logic                                           ctl_ready,
    output logic [`CPU_CTL_NUM_REGS-1:0]                   write_en,
    output logic [`CPU_CTL_NUM_REGS*`CPU_CTL_NUM_BUSES-1:0] output_en,
    output alu_op_t                                        alu_op,
    output logic [3:0]                                     alu_logic_func,
    output logic                                           alu_cin,
    output logic [`CPU_CTL_ROUTE_W-1:0]                    ctl_route,
    output logic [`CPU_CTL_WORD_W-1:0]                     immediate,
    input  logic                                           alu_cout
);

    insn_t fetch_insn, seq_insn;
    logic  fetch_valid, fetch_ready, seq_insn_valid, seq_insn_ready;
    uop_t  seq_uop, enc_uop;
    logic  seq_uop_valid, seq_uop_ready, enc_uop_valid, enc_uop_ready;

    insn_fetch fetch_i (
        .clk, .reset, .byte_data, .byte_valid, .byte_ready,
        .insn(fetch_insn), .insn_valid(fetch_valid), .insn_ready(fetch_ready)
    );

    stage_reg #(.payload_t(insn_t)) insn_stage_i (
        .clk, .reset,
        .in_data(fetch_insn), .in_valid(fetch_valid), .in_ready(fetch_ready),
        .out_data(seq_insn), .out_valid(seq_insn_valid), .out_ready(seq_insn_ready)
    );

    micro_sequencer seq_i (
        .clk, .reset,
        .insn(seq_insn), .insn_valid(seq_insn_valid), .insn_ready(seq_insn_ready),
        .uop(seq_uop), .uop_valid(seq_uop_valid), .uop_ready(seq_uop_ready)
    );

    stage_reg #(.payload_t(uop_t)) uop_stage_i (
        .clk, .reset,
        .in_data(seq_uop), .in_valid(seq_uop_valid), .in_ready(seq_uop_ready),
        .out_data(enc_uop), .out_valid(enc_uop_valid), .out_ready(enc_uop_ready)
    );

    control_encoder enc_i (
        .clk, .reset,
        .uop(enc_uop), .uop_valid(enc_uop_valid), .uop_ready(enc_uop_ready),
        .ctl_valid, .ctl_ready, .write_en, .output_en, .alu_op, .alu_logic_func,
        .alu_cin, .ctl_route, .immediate, .alu_cout
    );

endmodule

/* insn_fetch.sv */
`timescale 1ns/10ps
`include "cpu_ctl_cfg.svh"

module insn_fetch import cpu_ctl_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`CPU_CTL_BYTE_W-1:0] byte_data,
    input  logic                       byte_valid,
    output logic                       byte_ready,
    output insn_t                      insn,
    output logic                       insn_valid,
    input  logic                       insn_ready
);

    logic [`CPU_CTL_INSN_W-1:0] insn_q;
    logic [2:0]                 byte_cnt;
    logic [3:0]                 opcode;
    logic [2:0]                 len;
    logic                       byte_fire;

    // Instruction length in bytes for every opcode, dropped ones included
    function automatic logic [2:0] insn_len(input logic [3:0] op);
        case (op)
            `CPU_CTL_OP_PUSH, `CPU_CTL_OP_POP: return 3'd1;
            `CPU_CTL_OP_LFUN_RR, `CPU_CTL_OP_ADD_RR, `CPU_CTL_OP_SUB_RR,
            `CPU_CTL_OP_ROT_RR, `CPU_CTL_OP_ROT_RC: return 3'd2;
            `CPU_CTL_OP_ADD_RC, `CPU_CTL_OP_MOV_RC, `CPU_CTL_OP_CALL: return 3'd3;
            default: return 3'd4;
        endcase
    endfunction

    // The opcode is taken straight from the bus while byte 0 arrives
    assign opcode     = (byte_cnt == 3'd0) ? byte_data[7:4] : insn_q[7:4];
    assign len        = insn_len(opcode);
    assign byte_ready = !insn_valid;
    assign byte_fire  = byte_valid && byte_ready;
    assign insn       = insn_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            byte_cnt   <= 3'd0;
            insn_valid <= 1'b0;
        end else if (insn_valid && insn_ready) begin
            byte_cnt   <= 3'd0;
            insn_valid <= 1'b0;
        end else if (byte_fire) begin
            byte_cnt <= byte_cnt + 3'd1;
            if (byte_cnt + 3'd1 == len) begin
                insn_valid <= 1'b1;
            end
        end
    end

    // Unused upper bytes of short instructions read as zero
    always_ff @(posedge clk) begin
        if (byte_fire) begin
            if (byte_cnt == 3'd0) begin
                insn_q <= {{(`CPU_CTL_INSN_W - `CPU_CTL_BYTE_W){1'b0}}, byte_data};
            end else begin
                insn_q[{byte_cnt[1:0], 3'b000} +: `CPU_CTL_BYTE_W] <= byte_data;
            end
        end
    end

    byte_cnt_range: assert property (
        @(posedge clk) disable iff (reset)
        byte_cnt <= 3'd4
    ) else $error("insn_fetch byte counter passed four");

endmodule

/* micro_sequencer.sv */
`timescale 1ns/10ps
`include "cpu_ctl_cfg.svh"

module micro_sequencer import cpu_ctl_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  insn_t insn,
    input  logic  insn_valid,
    output logic  insn_ready,
    output uop_t  uop,
    output logic  uop_valid,
    input  logic  uop_ready
);

    logic step;
    logic last_step;
    logic dropped;

    assign dropped = insn.opcode inside {`CPU_CTL_OP_PUSH, `CPU_CTL_OP_POP,
                                         `CPU_CTL_OP_LOAD, `CPU_CTL_OP_STORE};
    // Only CALL has a second step
    assign last_step  = (insn.opcode != `CPU_CTL_OP_CALL) || step;
    assign uop_valid  = insn_valid && !dropped;
    assign insn_ready = dropped || (uop_ready && last_step);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step <= 1'b0;
        end else if (uop_valid && uop_ready) begin
            step <= !last_step;
        end
    end

    ////////////////////////////////////////
    // Field decode per opcode
    ////////////////////////////////////////

    always_comb begin
        uop = '0;
        uop.dest       = insn.a;
        uop.logic_func = insn.c;
        case (insn.opcode)
            `CPU_CTL_OP_LFUN_RR: begin
                uop.kind       = UOP_ALU_RR;
                uop.bus_en     = 3'b011;
                uop.bus_reg[0] = insn.a;
                uop.bus_reg[1] = insn.b;
                uop.alu_op     = ALU_LOGIC;
            end
            `CPU_CTL_OP_ADD_RR, `CPU_CTL_OP_SUB_RR, `CPU_CTL_OP_ROT_RR: begin
                uop.kind       = UOP_ALU_RR;
                uop.dest       = insn.b;
                uop.bus_en     = 3'b011;
                uop.bus_reg[0] = insn.b;
                uop.bus_reg[1] = insn.c;
                uop.use_carry  = insn.a[3];
                uop.sets_carry = (insn.opcode != `CPU_CTL_OP_ROT_RR);
                case (insn.opcode)
                    `CPU_CTL_OP_ADD_RR: uop.alu_op = ALU_ADD;
                    `CPU_CTL_OP_SUB_RR: uop.alu_op = ALU_SUB;
                    default:            uop.alu_op = insn.a[3] ? ALU_ROTC : ALU_ROT;
                endcase
            end
            `CPU_CTL_OP_ROT_RC: begin
                // The rotate amount is the 4-bit field c
                uop.kind       = UOP_ALU_RI;
                uop.bus_en     = 3'b001;
                uop.bus_reg[0] = insn.a;
                uop.use_carry  = insn.a[3];
                uop.alu_op     = insn.a[3] ? ALU_ROTC : ALU_ROT;
                uop.imm        = {{(`CPU_CTL_WORD_W - 4){1'b0}}, insn.c};
            end
            `CPU_CTL_OP_ADD_RC: begin
                uop.kind       = UOP_ALU_RI;
                uop.bus_en     = 3'b001;
                uop.bus_reg[0] = insn.a;
                uop.alu_op     = ALU_ADD;
                uop.imm        = short_imm(insn);
            end
            `CPU_CTL_OP_MOV_RC: begin
                uop.kind = UOP_IMM;
                uop.imm  = short_imm(insn);
            end
            `CPU_CTL_OP_CALL: begin
                if (!step) begin
                    // Save the return address from the PC on bus B
                    uop.kind       = UOP_PC;
                    uop.dest       = `CPU_CTL_LINK_REG;
                    uop.bus_en     = 3'b010;
                    uop.bus_reg[1] = `CPU_CTL_PC_REG;
                end else begin
                    uop.kind       = UOP_ALU_RI;
                    uop.dest       = `CPU_CTL_PC_REG;
                    uop.bus_en     = 3'b001;
                    uop.bus_reg[0] = insn.a;
                    uop.alu_op     = ALU_ADD;
                    uop.imm        = short_imm(insn);
                end
            end
            `CPU_CTL_OP_LFUN_RC: begin
                uop.kind       = UOP_ALU_RI;
                uop.dest       = insn.b;
                uop.bus_en     = 3'b001;
                uop.bus_reg[0] = insn.b;
                uop.alu_op     = ALU_LOGIC;
                uop.imm        = long_imm(insn);
            end
            `CPU_CTL_OP_BEZ, `CPU_CTL_OP_BNEZ: begin
                uop.kind       = UOP_ALU_RI;
                uop.dest       = `CPU_CTL_PC_REG;
                uop.bus_en     = 3'b101;
                uop.bus_reg[0] = insn.b;
                uop.bus_reg[2] = insn.c;
                uop.alu_op     = (insn.opcode == `CPU_CTL_OP_BEZ) ? ALU_BEZ : ALU_BNEZ;
                uop.imm        = long_imm(insn);
            end
            `CPU_CTL_OP_BGEZ: begin
                // The sign test reads its operand from bus B here
                uop.kind       = UOP_ALU_RI;
                uop.dest       = `CPU_CTL_PC_REG;
                uop.bus_en     = 3'b011;
                uop.bus_reg[0] = insn.b;
                uop.bus_reg[1] = insn.c;
                uop.alu_op     = ALU_BGEZ;
                uop.imm        = long_imm(insn);
            end
            default: begin
            end
        endcase
    end

    no_dropped_opcode: assert property (
        @(posedge clk) disable iff (reset)
        insn_valid |-> !dropped
    ) else $error("micro_sequencer received an unsupported opcode");

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps -f sim.f \
    --top-module tb_cpu_ctl -o tb_cpu_ctl_sim &&
./obj_dir/tb_cpu_ctl_sim | tee /dev/stderr | grep -q "All tests passed!" &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }

/* sim.f */
+incdir+.
stage_reg.sv
cpu_ctl_pkg.sv
insn_fetch.sv
micro_sequencer.sv
control_encoder.sv
cpu_ctl_top.sv
tb_cpu_ctl.sv

/* stage_reg.sv */
`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    // Accept when empty or when the held item leaves on this edge
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // A stalled item must be presented unchanged on the next cycle
    stall_holds_data: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("stage_reg output changed while stalled");

endmodule

/* tb_cpu_ctl.sv */
`timescale 1ns/10ps
`include "cpu_ctl_cfg.svh"

module tb_cpu_ctl import cpu_ctl_pkg::*; ();

    localparam int PER_LINE_CYCLES = 60;
    localparam int DRAIN_CYCLES    = 20;

    logic                                            clk;
    logic                                            reset;
    logic [`CPU_CTL_BYTE_W-1:0]                      byte_data;
    logic                                            byte_valid;
    logic                                            byte_ready;
    logic                                            ctl_valid;
    logic                                            ctl_ready;
    logic [`CPU_CTL_NUM_REGS-1:0]                    write_en;
    logic [`CPU_CTL_NUM_REGS*`CPU_CTL_NUM_BUSES-1:0] output_en;
    alu_op_t                                         alu_op;
    logic [3:0]                                      alu_logic_func;
    logic                                            alu_cin;
    logic [`CPU_CTL_ROUTE_W-1:0]                     ctl_route;
    logic [`CPU_CTL_WORD_W-1:0]                      immediate;
    logic                                            alu_cout;

    // One entry per test, per stream byte and per expected control word
    string       test_name [$];
    logic [7:0]  byte_q [$];
    int          word_test [$];
    logic        word_cout [$];
    logic [15:0] exp_we [$];
    logic [47:0] exp_oe [$];
    logic [3:0]  exp_op [$];
    logic        exp_cin [$];
    logic [15:0] exp_imm [$];
    logic [10:0] exp_route [$];
    logic        exp_lf_chk [$];
    logic [3:0]  exp_lf [$];

    int error_count   = 0;
    int test_errors   = 0;
    int tests_passed  = 0;
    int tests_failed  = 0;
    int cycle_cnt     = 0;
    int timeout_limit = 0;

    cpu_ctl_top dut_i (
        .clk, .reset, .byte_data, .byte_valid, .byte_ready,
        .ctl_valid, .ctl_ready, .write_en, .output_en, .alu_op, .alu_logic_func,
        .alu_cin, .ctl_route, .immediate, .alu_cout
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (timeout_limit > 0);
        wait (cycle_cnt >= timeout_limit);
        $display("ERROR: the run did not finish within %0d cycles", timeout_limit);
        $display("Test failures found");
        $finish;
    end

    ////////////////////////////////////////
    // Pattern file and checks
    ////////////////////////////////////////

    task automatic load_patterns();
        int          fd;
        int          n;
        int          len;
        int          nwords;
        string       line;
        string       name;
        logic        cout;
        logic        lfun;
        logic [7:0]  b [4];
        logic [15:0] we [2];
        logic [47:0] oe [2];
        logic [3:0]  op [2];
        logic        cin [2];
        logic [15:0] imm [2];
        logic [10:0] route [2];
        fd = $fopen("tb_patterns.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the pattern file tb_patterns.txt could not be opened");
            error_count++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %d %h %h %h %h %h %d %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, len, b[0], b[1], b[2], b[3], cout, nwords,
                        we[0], oe[0], op[0], cin[0], imm[0], route[0],
                        we[1], oe[1], op[1], cin[1], imm[1], route[1]);
            if (n != 20 || len < 1 || len > 4 || nwords < 1 || nwords > 2) begin
                $display("ERROR: malformed pattern line %s", line);
                error_count++;
                continue;
            end
            // Logic forms carry their function in field c, the low nibble of byte 1
            lfun = (b[0][7:4] == `CPU_CTL_OP_LFUN_RR) || (b[0][7:4] == `CPU_CTL_OP_LFUN_RC);
            test_name.push_back(name);
            for (int i = 0; i < len; i++) begin
                byte_q.push_back(b[i]);
            end
            for (int i = 0; i < nwords; i++) begin
                word_test.push_back(test_name.size() - 1);
                word_cout.push_back(cout);
                exp_we.push_back(we[i]);
                exp_oe.push_back(oe[i]);
                exp_op.push_back(op[i]);
                exp_cin.push_back(cin[i]);
                exp_imm.push_back(imm[i]);
                exp_route.push_back(route[i]);
                exp_lf_chk.push_back(lfun);
                exp_lf.push_back(b[1][3:0]);
            end
        end
        $fclose(fd);
        timeout_limit = PER_LINE_CYCLES * test_name.size();
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s expected %0h actual %0h", name, field, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_word(input int w);
        string name;
        name = test_name[word_test[w]];
        check_value(name, "write_en", 64'(exp_we[w]), 64'(write_en));
        check_value(name, "output_en", 64'(exp_oe[w]), 64'(output_en));
        check_value(name, "alu_op", 64'(exp_op[w]), 64'(alu_op));
        check_value(name, "alu_cin", 64'(exp_cin[w]), 64'(alu_cin));
        check_value(name, "immediate", 64'(exp_imm[w]), 64'(immediate));
        check_value(name, "ctl_route", 64'(exp_route[w]), 64'(ctl_route));
        if (exp_lf_chk[w]) begin
            check_value(name, "alu_logic_func", 64'(exp_lf[w]), 64'(alu_logic_func));
        end
    endtask

    task automatic report_test(input int t);
        if (test_errors == 0) begin
            tests_passed++;
            $display("PASS %s", test_name[t]);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d mismatches", test_name[t], test_errors);
        end
        test_errors = 0;
    endtask

    // Right after reset the pipeline is empty and takes bytes
    task automatic check_reset_state();
        @(negedge clk);
        check_value("reset", "byte_ready", 64'd1, 64'(byte_ready));
        check_value("reset", "ctl_valid", 64'd0, 64'(ctl_valid));
        check_value("reset", "write_en", 64'd0, 64'(write_en));
        check_value("reset", "output_en", 64'd0, 64'(output_en));
        test_errors = 0;
    endtask

    ////////////////////////////////////////
    // Byte source and control word sink
    ////////////////////////////////////////

    // A byte stays on the bus until it is taken, gaps are random
    task automatic send_bytes();
        int   idx;
        logic sent;
        idx  = 0;
        sent = 1'b0;
        while (idx < byte_q.size()) begin
            @(posedge clk);
            #1;
            if (sent) begin
                byte_valid = 1'b0;
                sent       = 1'b0;
            end
            if (!byte_valid && ($urandom % 4) != 0) begin
                byte_valid = 1'b1;
                byte_data  = byte_q[idx];
            end
            @(negedge clk);
            if (byte_valid && byte_ready) begin
                idx++;
                sent = 1'b1;
            end
        end
        @(posedge clk);
        #1;
        byte_valid = 1'b0;
    endtask

    // A word seen with both valid and ready at the falling edge leaves on the next rise
    task automatic receive_words();
        int w;
        int t;
        w = 0;
        while (w < exp_we.size()) begin
            @(posedge clk);
            #1;
            ctl_ready = ($urandom % 3) != 0;
            alu_cout  = word_cout[w];
            @(negedge clk);
            if (ctl_valid && ctl_ready) begin
                check_word(w);
                t = word_test[w];
                w++;
                if (w == exp_we.size() || word_test[w] != t) begin
                    report_test(t);
                end
            end
        end
        @(posedge clk);
        #1;
        ctl_ready = 1'b1;
    endtask

    task automatic check_no_extra_words();
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            check_value("drain", "ctl_valid", 64'd0, 64'(ctl_valid));
        end
    endtask

    initial begin
        reset      = 1'b1;
        byte_data  = '0;
        byte_valid = 1'b0;
        ctl_ready  = 1'b0;
        alu_cout   = 1'b0;
        void'($urandom(32'ha4ca_cd6c));
        load_patterns();
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        if (exp_we.size() == 0) begin
            $display("ERROR: no control words were loaded from the pattern file");
            error_count++;
        end else begin
            check_reset_state();
            fork
                send_bytes();
                receive_words();
            join
            check_no_extra_words();
        end
        $display("%0d tests: %0d passed, %0d failed, %0d errors",
                 test_name.size(), tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tb_patterns.txt */
# name len b0 b1 b2 b3 cout words, then per word: write_en output_en alu_op cin imm route
# len and words are decimal, the rest hex, cout is alu_cout while the test's words leave
lfun_rr   2 25 73 00 00 0 1 0020 000000408000 4 0 0000 083 0000 000000000000 0 0 0000 000
add_rr    2 30 21 00 00 1 1 0004 000000000050 0 0 0000 083 0000 000000000000 0 0 0000 000
add_rr_c  2 38 45 00 00 0 1 0010 000000011000 0 1 0000 083 0000 000000000000 0 0 0000 000
sub_rr    2 40 9a 00 00 1 1 0200 000088000000 2 1 0000 083 0000 000000000000 0 0 0000 000
rot_rr    2 50 6e 00 00 0 1 0040 080000040000 3 1 0000 083 0000 000000000000 0 0 0000 000
sub_rr_c  2 48 b3 00 00 0 1 0800 000200000400 2 1 0000 083 0000 000000000000 0 0 0000 000
rotc_rc   2 6a 05 00 00 0 1 0400 000040000000 1 0 0005 085 0000 000000000000 0 0 0000 000
add_rc    3 73 34 12 00 0 1 0008 000000000200 0 0 1234 085 0000 000000000000 0 0 0000 000
mov_rc    3 8c ef be 00 0 1 1000 000000000000 0 0 beef 140 0000 000000000000 0 0 0000 000
call_a    3 97 00 40 00 0 2 8000 000000000002 0 0 0000 040 0001 000000200000 0 0 4000 085
lfun_rc   4 a0 5d 78 56 0 1 0020 000000008000 4 0 5678 085 0000 000000000000 0 0 0000 000
bez       4 b0 12 cd ab 0 1 0001 000000000108 5 0 abcd 085 0000 000000000000 0 0 0000 000
bnez      4 c0 34 01 80 0 1 0001 000000004200 6 0 8001 085 0000 000000000000 0 0 0000 000
bgez      4 d0 56 ff 00 0 1 0001 000000088000 7 0 00ff 085 0000 000000000000 0 0 0000 000
add_rr_co 2 30 fe 00 00 1 1 8000 280000000000 0 0 0000 083 0000 000000000000 0 0 0000 000
rotc_rr   2 58 10 00 00 0 1 0002 00000000000a 1 1 0000 083 0000 000000000000 0 0 0000 000
sub_rr_nc 2 40 77 00 00 0 1 0080 000000600000 2 1 0000 083 0000 000000000000 0 0 0000 000
add_rr_c0 2 38 88 00 00 1 1 0100 000003000000 0 0 0000 083 0000 000000000000 0 0 0000 000
call_b    3 9d 10 00 00 0 2 8000 000000000002 0 0 0000 040 0001 008000000000 0 0 0010 085
